/* rtl/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INSN_W     = 32;

    // major opcodes, insn[6:0]
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // sub / sra

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B // lui
    } alu_op_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic [XLEN-1:0]        op_a;
        logic [XLEN-1:0]        op_b;
        logic [REG_ADDR_W-1:0]  rd_addr;
        logic                   rd_we;     // already cleared for x0
        logic                   is_branch;
        logic                   br_taken;
        logic [XLEN-1:0]        br_target;
        logic                   illegal;
    } ex_payload_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd_addr;
        logic [XLEN-1:0]        data;
    } wb_payload_t;

endpackage

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_2,
    output logic [rv_pkg::XLEN-1:0]       rd_data_1,
    output logic [rv_pkg::XLEN-1:0]       rd_data_2,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [rv_pkg::XLEN-1:0]       wr_data
);

    logic [rv_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];
    assign rd_data_2 = (rd_addr_2 == '0) ? '0 : regs[rd_addr_2];

endmodule

/* rtl/rv_forward.sv */
`timescale 1ns/1ps

module rv_forward (
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rv_pkg::XLEN-1:0]       rf_data_1,
    input  logic [rv_pkg::XLEN-1:0]       rf_data_2,
    input  logic                          ex_fwd_valid, // valid and write flag
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_fwd_addr,
    input  logic [rv_pkg::XLEN-1:0]       ex_fwd_data,
    input  logic                          wb_fwd_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_fwd_addr,
    input  logic [rv_pkg::XLEN-1:0]       wb_fwd_data,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data
);

    // newest value wins: execute, then write-back, then the file
    function automatic logic [rv_pkg::XLEN-1:0] select_src(
        input logic [rv_pkg::REG_ADDR_W-1:0] addr,
        input logic [rv_pkg::XLEN-1:0]       rf_data
    );
        if (ex_fwd_valid && (ex_fwd_addr == addr)) begin
            return ex_fwd_data;
        end else if (wb_fwd_valid && (wb_fwd_addr == addr)) begin
            return wb_fwd_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_data = select_src(rs1_addr, rf_data_1);
        rs2_data = select_src(rs2_addr, rf_data_2);
    end

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_pkg::INSN_W-1:0]     insn,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data,
    output rv_pkg::ex_payload_t           ex_payload
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]       imm_i;
    logic [rv_pkg::XLEN-1:0]       imm_b;
    logic [rv_pkg::XLEN-1:0]       imm_u;
    logic                          f7_base;
    logic                          f7_alt;

    assign opcode   = insn[6:0];
    assign rd       = insn[11:7];
    assign funct3   = insn[14:12];
    assign rs1_addr = insn[19:15];
    assign rs2_addr = insn[24:20];
    assign funct7   = insn[31:25];

    assign imm_i = {{(rv_pkg::XLEN-12){insn[31]}}, insn[31:20]};
    assign imm_b = {{(rv_pkg::XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};

    assign f7_base = (funct7 == rv_pkg::FUNCT7_BASE);
    assign f7_alt  = (funct7 == rv_pkg::FUNCT7_ALT);

    always_comb begin
        ex_payload           = '0;
        ex_payload.alu_op    = rv_pkg::ALU_ADD;
        ex_payload.op_a      = rs1_data;
        ex_payload.op_b      = rs2_data;
        ex_payload.rd_addr   = rd;
        ex_payload.br_target = pc + imm_b; // pc belongs to this insn
        case (opcode)
            rv_pkg::OP_OP, rv_pkg::OP_IMM: begin
                ex_payload.rd_we = 1'b1;
                if (opcode == rv_pkg::OP_IMM) begin
                    ex_payload.op_b = imm_i; // shifts only look at imm[4:0]
                end
                case (funct3)
                    rv_pkg::FUNCT3_ADD_SUB: begin
                        // no subi: OP-IMM ignores funct7 here
                        if (opcode == rv_pkg::OP_OP) begin
                            ex_payload.alu_op  = f7_alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                            ex_payload.illegal = !(f7_base || f7_alt);
                        end
                    end
                    rv_pkg::FUNCT3_SLL: begin
                        ex_payload.alu_op  = rv_pkg::ALU_SLL;
                        ex_payload.illegal = !f7_base;
                    end
                    rv_pkg::FUNCT3_SRL_SRA: begin
                        ex_payload.alu_op  = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        ex_payload.illegal = !(f7_base || f7_alt);
                    end
                    default: begin
                        // slt/sltu/xor/or/and, immediate forms carry no funct7
                        case (funct3)
                            rv_pkg::FUNCT3_SLT:  ex_payload.alu_op = rv_pkg::ALU_SLT;
                            rv_pkg::FUNCT3_SLTU: ex_payload.alu_op = rv_pkg::ALU_SLTU;
                            rv_pkg::FUNCT3_XOR:  ex_payload.alu_op = rv_pkg::ALU_XOR;
                            rv_pkg::FUNCT3_OR:   ex_payload.alu_op = rv_pkg::ALU_OR;
                            default:             ex_payload.alu_op = rv_pkg::ALU_AND;
                        endcase
                        ex_payload.illegal = (opcode == rv_pkg::OP_OP) && !f7_base;
                    end
                endcase
            end
            rv_pkg::OP_LUI: begin
                ex_payload.alu_op = rv_pkg::ALU_PASS_B;
                ex_payload.op_b   = imm_u;
                ex_payload.rd_we  = 1'b1;
            end
            rv_pkg::OP_BRANCH: begin
                ex_payload.is_branch = 1'b1;
                case (funct3)
                    rv_pkg::FUNCT3_BEQ:  ex_payload.br_taken = (rs1_data == rs2_data);
                    rv_pkg::FUNCT3_BNE:  ex_payload.br_taken = (rs1_data != rs2_data);
                    rv_pkg::FUNCT3_BLT:  ex_payload.br_taken = ($signed(rs1_data) < $signed(rs2_data));
                    rv_pkg::FUNCT3_BGE:  ex_payload.br_taken = ($signed(rs1_data) >= $signed(rs2_data));
                    rv_pkg::FUNCT3_BLTU: ex_payload.br_taken = (rs1_data < rs2_data);
                    rv_pkg::FUNCT3_BGEU: ex_payload.br_taken = (rs1_data >= rs2_data);
                    default:             ex_payload.illegal  = 1'b1; // 010, 011
                endcase
            end
            default: ex_payload.illegal = 1'b1; // unknown opcode
        endcase

        // an undefined insn leaves no other outcome behind
        if (ex_payload.illegal) begin
            ex_payload.rd_we     = 1'b0;
            ex_payload.is_branch = 1'b0;
            ex_payload.br_taken  = 1'b0;
        end
        if (rd == '0) begin
            ex_payload.rd_we = 1'b0; // x0 is never written nor forwarded
        end
    end

endmodule

/* rtl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t          op,
    input  logic [rv_pkg::XLEN-1:0]  in_a,
    input  logic [rv_pkg::XLEN-1:0]  in_b,
    output logic [rv_pkg::XLEN-1:0]  result
);

    logic [4:0] shamt;

    assign shamt = in_b[4:0]; // rs2[4:0] or imm[4:0]

    always_comb begin
        result = '0;
        case (op)
            rv_pkg::ALU_ADD:    result = in_a + in_b;
            rv_pkg::ALU_SUB:    result = in_a - in_b;
            rv_pkg::ALU_SLT:    result[0] = ($signed(in_a) < $signed(in_b));
            rv_pkg::ALU_SLTU:   result[0] = (in_a < in_b); // sltiu: sign-extended imm compared unsigned
            rv_pkg::ALU_AND:    result = in_a & in_b;
            rv_pkg::ALU_OR:     result = in_a | in_b;
            rv_pkg::ALU_XOR:    result = in_a ^ in_b;
            rv_pkg::ALU_SLL:    result = in_a << shamt;
            rv_pkg::ALU_SRL:    result = in_a >> shamt;
            rv_pkg::ALU_SRA:    result = $signed(in_a) >>> shamt;
            rv_pkg::ALU_PASS_B: result = in_b;
            default:            result = '0;
        endcase
    end

endmodule

/* rtl/rv_stage_reg.sv */
`timescale 1ns/1ps

module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid; // one entry per cycle, never stalls
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_payload <= in_payload; // holds the last entry while idle
        end
    end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          insn_valid,
    input  logic [rv_pkg::INSN_W-1:0]     insn,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    output logic                          wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic                          br_valid,
    output logic                          br_taken,
    output logic [rv_pkg::XLEN-1:0]       br_target,
    output logic                          illegal
);

    logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_pkg::XLEN-1:0]       rf_data_1;
    logic [rv_pkg::XLEN-1:0]       rf_data_2;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    rv_pkg::ex_payload_t           id_payload;
    logic                          ex_valid;
    rv_pkg::ex_payload_t           ex_payload;
    logic [rv_pkg::XLEN-1:0]       alu_result;
    logic                          ex_writes;
    rv_pkg::wb_payload_t           wb_next;
    rv_pkg::wb_payload_t           wb_payload;

    rv_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_1 (rs1_addr),
        .rd_addr_2 (rs2_addr),
        .rd_data_1 (rf_data_1),
        .rd_data_2 (rf_data_2),
        .we        (wb_valid),
        .wr_addr   (wb_payload.rd_addr),
        .wr_data   (wb_payload.data)
    );

    rv_forward u_forward (
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rf_data_1    (rf_data_1),
        .rf_data_2    (rf_data_2),
        .ex_fwd_valid (ex_writes),
        .ex_fwd_addr  (ex_payload.rd_addr),
        .ex_fwd_data  (alu_result),
        .wb_fwd_valid (wb_valid),
        .wb_fwd_addr  (wb_payload.rd_addr),
        .wb_fwd_data  (wb_payload.data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    rv_decoder u_decoder (
        .insn       (insn),
        .pc         (pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_payload (id_payload)
    );

    rv_stage_reg #(.payload_t(rv_pkg::ex_payload_t)) u_ex_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (insn_valid),
        .in_payload  (id_payload),
        .out_valid   (ex_valid),
        .out_payload (ex_payload)
    );

    rv_alu u_alu (
        .op     (ex_payload.alu_op),
        .in_a   (ex_payload.op_a),
        .in_b   (ex_payload.op_b),
        .result (alu_result)
    );

    assign ex_writes       = ex_valid && ex_payload.rd_we;
    assign wb_next.rd_addr = ex_payload.rd_addr;
    assign wb_next.data    = alu_result;

    rv_stage_reg #(.payload_t(rv_pkg::wb_payload_t)) u_wb_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (ex_writes),   // branches and illegal insns stop here
        .in_payload  (wb_next),
        .out_valid   (wb_valid),
        .out_payload (wb_payload)
    );

    assign wb_addr   = wb_payload.rd_addr;
    assign wb_data   = wb_payload.data;
    assign br_valid  = ex_valid && ex_payload.is_branch;
    assign br_taken  = ex_payload.br_taken;
    assign br_target = ex_payload.br_target;
    assign illegal   = ex_valid && ex_payload.illegal;

endmodule

/* tests/rv_core_props.sv */
`timescale 1ns/1ps

module rv_core_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          insn_valid,
    input logic                          ex_writes,
    input logic                          wb_valid,
    input logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    input logic                          br_valid,
    input logic                          illegal
);

    // the insn in execute has at most one outcome
    one_outcome: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ex_writes, br_valid, illegal}))
        else $error("execute stage reports more than one outcome");

    // write-back lands two cycles after the strobe, one after a branch or illegal would
    wb_two_after_insn: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> ($past(insn_valid, 2) && !$past(br_valid || illegal)))
        else $error("write-back strobe not two cycles after its instruction");

    no_x0_write: assert property (@(posedge clk) disable iff (rst) wb_valid |-> (wb_addr != '0))
        else $error("write-back strobe targets x0");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !(wb_valid || br_valid || illegal))
        else $error("strobe active in the cycle after reset");

    br_needs_insn: assert property (@(posedge clk) disable iff (rst) br_valid |-> $past(insn_valid))
        else $error("branch strobe without an instruction one cycle earlier");

endmodule

bind rv_core rv_core_props u_props (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .ex_writes  (ex_writes),
    .wb_valid   (wb_valid),
    .wb_addr    (wb_addr),
    .br_valid   (br_valid),
    .illegal    (illegal)
);

/* tests/tb.sv */
`timescale 1ns/1ps

module tb;

    logic        clk;
    logic        rst;
    logic        insn_valid;
    logic [31:0] insn;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        br_valid;
    logic        br_taken;
    logic [31:0] br_target;
    logic        illegal;

    logic [4:0]  exp_wb_addr[$];   // pending outcomes, oldest first
    logic [31:0] exp_wb_data[$];
    logic        exp_br_taken[$];
    logic [31:0] exp_br_target[$];
    int          exp_illegal;

    rv_core i_dut (
        .clk        (clk),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .pc         (pc),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .br_valid   (br_valid),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
                                    name, actual, expected));
        end
    endtask

    // outputs settle after the rising edge, so look at them mid-cycle
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_wb_addr.size() == 0) begin
                stop_on_error("a write-back strobe came with no write expected");
            end
            compare("wb_addr", wb_addr, exp_wb_addr.pop_front());
            compare("wb_data", wb_data, exp_wb_data.pop_front());
        end
        if (!rst && br_valid) begin
            if (exp_br_taken.size() == 0) begin
                stop_on_error("a branch strobe came with no branch expected");
            end
            compare("br_taken", br_taken, exp_br_taken.pop_front());
            compare("br_target", br_target, exp_br_target.pop_front());
        end
        if (!rst && illegal) begin
            if (exp_illegal == 0) begin
                stop_on_error("an illegal strobe came for a defined instruction");
            end
            exp_illegal--;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          waited;
        string       line;
        logic [31:0] gap;
        logic [31:0] pc_v;
        logic [31:0] insn_v;
        logic [31:0] kind;
        logic [31:0] field_a;
        logic [31:0] field_b;
        rst         = 1'b1;
        insn_valid  = 1'b0;
        insn        = '0;
        pc          = '0;
        exp_illegal = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        fd = $fopen("tests/core_input.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open tests/core_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h", gap, pc_v, insn_v, kind, field_a, field_b);
            if (n == 6) begin  // header and blank lines give fewer fields
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                    insn_valid = 1'b0;
                end
                @(posedge clk);
                #2;
                insn_valid = 1'b1;
                insn       = insn_v;
                pc         = pc_v;
                case (kind)
                    1: begin
                        exp_wb_addr.push_back(field_a[4:0]);
                        exp_wb_data.push_back(field_b);
                    end
                    2: begin
                        exp_br_taken.push_back(field_a[0]);
                        exp_br_target.push_back(field_b);
                    end
                    3: exp_illegal++;
                    default: ;  // x0 destination, no strobe at all
                endcase
            end
        end
        $fclose(fd);
        @(posedge clk);
        #2;
        insn_valid = 1'b0;

        waited = 0;
        while ((exp_wb_addr.size() != 0) && (waited < 50)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_wb_addr.size() != 0) begin
            stop_on_error("timeout: an expected write-back strobe never came");
        end
        waited = 0;
        while ((exp_br_taken.size() != 0) && (waited < 50)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_br_taken.size() != 0) begin
            stop_on_error("timeout: an expected branch strobe never came");
        end
        waited = 0;
        while ((exp_illegal != 0) && (waited < 50)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_illegal != 0) begin
            stop_on_error("timeout: an expected illegal strobe never came");
        end

        repeat (4) @(posedge clk);  // idle tail, any stray strobe still fails
        $display("Test passed");
        $finish;
    end

endmodule

/* tests/core_input.txt */
# columns, all hex: gap pc insn kind a b; gap is idle cycles before the instruction
# kind 0 none, 1 write (a rd, b data), 2 branch (a taken, b target), 3 illegal
4 00000100 00838133 1 02 00000000
0 00000104 00500093 1 01 00000005
0 00000108 ffd08193 1 03 00000002
0 0000010c 40118233 1 04 fffffffd
1 00000110 401252b3 1 05 ffffffff
0 00000114 00125333 1 06 07ffffff
0 00000118 ffe22393 1 07 00000001
0 0000011c fff0b413 1 08 00000001
0 00000120 12345537 1 0a 12345000
0 00000124 67856513 1 0a 12345678
0 00000128 fff54593 1 0b edcba987
0 0000012c 01100693 1 0d 00000011
0 00000130 02200693 1 0d 00000022
0 00000134 00469713 1 0e 00000220
0 00000138 00708013 0 00 00000000
0 0000013c 001007b3 1 0f 00000005
0 00000140 ffffffff 3 00 00000000
0 00000144 02108833 3 00 00000000
0 00000148 00178833 1 10 0000000a
0 0000014c 00181463 2 01 00000154
0 00000150 fe1248e3 2 01 00000140
0 00000154 00125463 2 00 0000015c
0 00000158 00126463 2 00 00000160
0 0000015c fe1278e3 2 01 0000014c
0 00000160 00500893 1 11 00000005
0 00000164 00188463 2 01 0000016c
2 00000168 01106933 1 12 00000005

/* tb.f */
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_forward.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_stage_reg.sv
rtl/rv_core.sv
tests/rv_core_props.sv
tests/tb.sv
